/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing -j 0
TOP       := tb_superscalar_core
FILELIST  := tb.f
OBJ_DIR   := obj_dir

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# exit status of the simulation is the pass or fail result
run: compile
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)

/* source/alu.sv */
`timescale 1ns/10ps
`include "core_consts.svh"

module alu (
    input  core_pkg::alu_op_e op_i,
    input  core_pkg::xlen_t   a_i,
    input  core_pkg::xlen_t   b_i,
    output core_pkg::xlen_t   result_o
);
    import core_pkg::*;

    logic [4:0] shamt;

    assign shamt = b_i[4:0];

    always_comb begin
        case (op_i)
            alu_add: begin
                result_o = a_i + b_i;
            end
            alu_sub: begin
                result_o = a_i - b_i;
            end
            alu_sll: begin
                result_o = a_i << shamt;
            end
            alu_slt: begin
                result_o = xlen_t'($signed(a_i) < $signed(b_i));
            end
            alu_sltu: begin
                result_o = xlen_t'(a_i < b_i);
            end
            alu_xor: begin
                result_o = a_i ^ b_i;
            end
            alu_srl: begin
                result_o = a_i >> shamt;
            end
            alu_sra: begin
                result_o = xlen_t'($signed(a_i) >>> shamt);
            end
            alu_or: begin
                result_o = a_i | b_i;
            end
            default: begin
                result_o = a_i & b_i;
            end
        endcase
    end

endmodule

/* source/core_consts.svh */
`ifndef CORE_CONSTS_SVH
`define CORE_CONSTS_SVH

// lanes fetched, decoded and issued per cycle
`define ISSUE_WIDTH 4

`define XLEN 32
`define NUM_REGS 32
`define REG_ADDR_W 5

// instruction memory is word addressed
`define FETCH_ADDR_W 32

// RV32I major opcodes handled by the core
`define OPC_OP 7'b0110011
`define OPC_OP_IMM 7'b0010011

`endif

/* source/core_pkg.sv */
`include "core_consts.svh"

package core_pkg;

    typedef logic [`XLEN-1:0] xlen_t;
    typedef logic [31:0] insn_t;
    typedef logic [`REG_ADDR_W-1:0] reg_addr_t;
    typedef logic [`FETCH_ADDR_W-1:0] fetch_addr_t;
    typedef logic [`ISSUE_WIDTH-1:0] lane_mask_t;
    // 0 to ISSUE_WIDTH lanes
    typedef logic [$clog2(`ISSUE_WIDTH+1)-1:0] issue_cnt_t;

    typedef enum logic [3:0] {
        alu_add,
        alu_sub,
        alu_sll,
        alu_slt,
        alu_sltu,
        alu_xor,
        alu_srl,
        alu_sra,
        alu_or,
        alu_and
    } alu_op_e;

    // decoded micro-op, one per lane
    typedef struct packed {
        logic      valid;
        logic      writes_rd;
        alu_op_e   alu_op;
        reg_addr_t rd;
        reg_addr_t rs1;
        reg_addr_t rs2;
        logic      use_imm;
        xlen_t     imm;
    } uop_t;

    // execute register entry, operands already selected
    typedef struct packed {
        logic      writes_rd;
        alu_op_e   alu_op;
        reg_addr_t rd;
        xlen_t     a;
        xlen_t     b;
    } exec_t;

    typedef struct packed {
        reg_addr_t rd;
        xlen_t     data;
    } commit_t;

    typedef insn_t [`ISSUE_WIDTH-1:0] fetch_bundle_t;
    typedef commit_t [`ISSUE_WIDTH-1:0] commit_bundle_t;

endpackage

/* source/exec_pipe.sv */
`timescale 1ns/10ps
`include "core_consts.svh"

module exec_pipe (
    input  logic                                 clk,
    input  logic                                 rst,
    input  core_pkg::uop_t  [`ISSUE_WIDTH-1:0]   uops_i,
    input  core_pkg::lane_mask_t                 issue_mask_i,
    input  core_pkg::xlen_t [`ISSUE_WIDTH-1:0]   rdata1_i,
    input  core_pkg::xlen_t [`ISSUE_WIDTH-1:0]   rdata2_i,
    output core_pkg::lane_mask_t                 exec_valid_o,
    output core_pkg::exec_t [`ISSUE_WIDTH-1:0]   exec_o,
    output core_pkg::lane_mask_t                 commit_valid_o,
    output core_pkg::commit_bundle_t             commit_o
);
    import core_pkg::*;

    lane_mask_t                 exec_valid_q;
    exec_t [`ISSUE_WIDTH-1:0]   exec_q;
    lane_mask_t                 commit_valid_q;
    commit_bundle_t             commit_q;
    xlen_t [`ISSUE_WIDTH-1:0]   alu_res;

    // only issued lanes with a real destination occupy the stage
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            exec_valid_q <= '0;
            commit_valid_q <= '0;
        end else begin
            for (int i = 0; i < `ISSUE_WIDTH; i++) begin
                exec_valid_q[i] <= issue_mask_i[i] && uops_i[i].writes_rd &&
                                   (uops_i[i].rd != '0);
            end
            commit_valid_q <= exec_valid_q;
        end
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < `ISSUE_WIDTH; i++) begin
            if (issue_mask_i[i]) begin
                exec_q[i].writes_rd <= uops_i[i].writes_rd;
                exec_q[i].alu_op <= uops_i[i].alu_op;
                exec_q[i].rd <= uops_i[i].rd;
                exec_q[i].a <= rdata1_i[i];
                exec_q[i].b <= uops_i[i].use_imm ? uops_i[i].imm : rdata2_i[i];
            end
            commit_q[i].rd <= exec_q[i].rd;
            commit_q[i].data <= alu_res[i];
        end
    end

    for (genvar g = 0; g < `ISSUE_WIDTH; g++) begin : g_alu
        alu i_alu (
            .op_i     (exec_q[g].alu_op),
            .a_i      (exec_q[g].a),
            .b_i      (exec_q[g].b),
            .result_o (alu_res[g])
        );
    end

    assign exec_valid_o = exec_valid_q;
    assign exec_o = exec_q;
    // writeback register feeds both the commit port and the register file
    assign commit_valid_o = commit_valid_q;
    assign commit_o = commit_q;

endmodule

/* source/fetch_window.sv */
`timescale 1ns/10ps
`include "core_consts.svh"

module fetch_window (
    input  logic                    clk,
    input  logic                    rst,
    input  core_pkg::fetch_bundle_t fetch_bundle_i,
    input  core_pkg::issue_cnt_t    issue_cnt_i,
    output core_pkg::fetch_bundle_t window_o,
    output core_pkg::lane_mask_t    window_valid_o,
    output core_pkg::fetch_addr_t   fetch_addr_o
);
    import core_pkg::*;

    fetch_bundle_t window_q;
    fetch_bundle_t window_d;
    lane_mask_t    valid_q;
    lane_mask_t    valid_d;
    fetch_addr_t   addr_q;
    issue_cnt_t    valid_cnt;
    issue_cnt_t    keep_cnt;
    issue_cnt_t    fill_cnt;

    // valid slots always form a prefix
    always_comb begin
        valid_cnt = '0;
        for (int i = 0; i < `ISSUE_WIDTH; i++) begin
            valid_cnt = valid_cnt + issue_cnt_t'(valid_q[i]);
        end
        keep_cnt = valid_cnt - issue_cnt_i;
        fill_cnt = issue_cnt_t'(`ISSUE_WIDTH) - keep_cnt;
    end

    // unissued slots move down, bundle words fill the rest
    always_comb begin
        logic [1:0] src;
        src = '0;
        for (int i = 0; i < `ISSUE_WIDTH; i++) begin
            if (i < int'(keep_cnt)) begin
                src = 2'(i + int'(issue_cnt_i));
                window_d[i] = window_q[src];
                valid_d[i] = valid_q[src];
            end else begin
                src = 2'(i - int'(keep_cnt));
                window_d[i] = fetch_bundle_i[src];
                valid_d[i] = 1'b1;
            end
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            valid_q <= '0;
            addr_q <= '0;
        end else begin
            valid_q <= valid_d;
            addr_q <= addr_q + fetch_addr_t'(fill_cnt);
        end
    end

    always_ff @(posedge clk) begin
        window_q <= window_d;
    end

    assign window_o = window_q;
    assign window_valid_o = valid_q;
    assign fetch_addr_o = addr_q;

endmodule

/* source/insn_decode.sv */
`timescale 1ns/10ps
`include "core_consts.svh"

module insn_decode (
    input  core_pkg::insn_t insn_i,
    input  logic            valid_i,
    output core_pkg::uop_t  uop_o
);
    import core_pkg::*;

    logic [6:0]  opcode;
    logic [2:0]  funct3;
    logic [6:0]  funct7;
    logic [11:0] imm12;
    logic        f7_zero;
    logic        f7_alt;
    logic        known;
    logic        is_imm;
    alu_op_e     base_op;
    alu_op_e     op;
    xlen_t       imm;

    assign opcode = insn_i[6:0];
    assign funct3 = insn_i[14:12];
    assign funct7 = insn_i[31:25];
    assign imm12 = insn_i[31:20];
    assign f7_zero = (funct7 == 7'b0000000);
    assign f7_alt = (funct7 == 7'b0100000);

    always_comb begin
        case (funct3)
            3'b000: base_op = alu_add;
            3'b001: base_op = alu_sll;
            3'b010: base_op = alu_slt;
            3'b011: base_op = alu_sltu;
            3'b100: base_op = alu_xor;
            3'b101: base_op = alu_srl;
            3'b110: base_op = alu_or;
            default: base_op = alu_and;
        endcase
    end

    always_comb begin
        known = 1'b0;
        is_imm = 1'b0;
        op = base_op;
        imm = {{(`XLEN-12){imm12[11]}}, imm12};
        if (opcode == `OPC_OP) begin
            known = f7_zero || (f7_alt && (funct3 == 3'b000 || funct3 == 3'b101));
            if (f7_alt) begin
                op = (funct3 == 3'b000) ? alu_sub : alu_sra;
            end
        end else if (opcode == `OPC_OP_IMM) begin
            is_imm = 1'b1;
            known = 1'b1;
            if (funct3 == 3'b001 || funct3 == 3'b101) begin
                // shift amount only
                imm = xlen_t'(insn_i[24:20]);
                known = f7_zero || (f7_alt && funct3 == 3'b101);
                op = f7_alt ? alu_sra : base_op;
            end
        end
    end

    // anything else flows through as a nop
    always_comb begin
        uop_o.valid = valid_i;
        uop_o.writes_rd = known;
        uop_o.alu_op = known ? op : alu_add;
        uop_o.rd = known ? insn_i[11:7] : '0;
        uop_o.rs1 = known ? insn_i[19:15] : '0;
        uop_o.rs2 = (known && !is_imm) ? insn_i[24:20] : '0;
        uop_o.use_imm = is_imm || !known;
        uop_o.imm = imm;
    end

endmodule

/* source/issue_logic.sv */
`timescale 1ns/10ps
`include "core_consts.svh"

module issue_logic (
    input  core_pkg::uop_t  [`ISSUE_WIDTH-1:0] uops_i,
    input  core_pkg::lane_mask_t               exec_valid_i,
    input  core_pkg::exec_t [`ISSUE_WIDTH-1:0] exec_i,
    output core_pkg::lane_mask_t               issue_mask_o,
    output core_pkg::issue_cnt_t               issue_cnt_o
);
    import core_pkg::*;

    lane_mask_t lane_ok;

    // true if u reads a nonzero register r
    function automatic logic reads_reg(uop_t u, reg_addr_t r);
        return (r != '0) && ((u.rs1 == r) || (!u.use_imm && (u.rs2 == r)));
    endfunction

    always_comb begin
        lane_ok = '0;
        for (int i = 0; i < `ISSUE_WIDTH; i++) begin
            lane_ok[i] = uops_i[i].valid;
            // scoreboard against the execute register
            for (int j = 0; j < `ISSUE_WIDTH; j++) begin
                if (exec_valid_i[j] && exec_i[j].writes_rd &&
                    reads_reg(uops_i[i], exec_i[j].rd)) begin
                    lane_ok[i] = 1'b0;
                end
            end
            // older lanes in the same window
            for (int k = 0; k < i; k++) begin
                if (uops_i[k].valid && uops_i[k].writes_rd &&
                    reads_reg(uops_i[i], uops_i[k].rd)) begin
                    lane_ok[i] = 1'b0;
                end
            end
        end
    end

    // in-order prefix, first blocked lane stops the rest
    always_comb begin
        logic in_order;
        in_order = 1'b1;
        issue_cnt_o = '0;
        for (int i = 0; i < `ISSUE_WIDTH; i++) begin
            in_order = in_order & lane_ok[i];
            issue_mask_o[i] = in_order;
            issue_cnt_o = issue_cnt_o + issue_cnt_t'(in_order);
        end
    end

endmodule

/* source/reg_file.sv */
`timescale 1ns/10ps
`include "core_consts.svh"

module reg_file (
    input  logic                                 clk,
    input  logic                                 rst,
    input  core_pkg::reg_addr_t [`ISSUE_WIDTH-1:0] raddr1_i,
    input  core_pkg::reg_addr_t [`ISSUE_WIDTH-1:0] raddr2_i,
    input  core_pkg::lane_mask_t                 wen_i,
    input  core_pkg::commit_bundle_t             wbundle_i,
    output core_pkg::xlen_t     [`ISSUE_WIDTH-1:0] rdata1_o,
    output core_pkg::xlen_t     [`ISSUE_WIDTH-1:0] rdata2_o
);
    import core_pkg::*;

    xlen_t regs [`NUM_REGS];

    // write-through, the highest matching lane wins like the array write
    function automatic xlen_t read_port(reg_addr_t a);
        xlen_t v;
        v = regs[a];
        for (int i = 0; i < `ISSUE_WIDTH; i++) begin
            if (wen_i[i] && wbundle_i[i].rd == a) begin
                v = wbundle_i[i].data;
            end
        end
        return (a == '0) ? '0 : v;
    endfunction

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int r = 0; r < `NUM_REGS; r++) begin
                regs[r] <= '0;
            end
        end else begin
            for (int i = 0; i < `ISSUE_WIDTH; i++) begin
                if (wen_i[i] && wbundle_i[i].rd != '0) begin
                    regs[wbundle_i[i].rd] <= wbundle_i[i].data;
                end
            end
        end
    end

    always_comb begin
        for (int i = 0; i < `ISSUE_WIDTH; i++) begin
            rdata1_o[i] = read_port(raddr1_i[i]);
            rdata2_o[i] = read_port(raddr2_i[i]);
        end
    end

endmodule

/* source/superscalar_core.sv */
`timescale 1ns/10ps
`include "core_consts.svh"

module superscalar_core (
    input  logic                     clk,
    input  logic                     rst,
    output core_pkg::fetch_addr_t    fetch_addr_o,
    input  core_pkg::fetch_bundle_t  fetch_bundle_i,
    output core_pkg::lane_mask_t     commit_valid_o,
    output core_pkg::commit_bundle_t commit_o
);
    import core_pkg::*;

    fetch_bundle_t                window;
    lane_mask_t                   window_valid;
    uop_t      [`ISSUE_WIDTH-1:0] uops;
    lane_mask_t                   issue_mask;
    issue_cnt_t                   issue_cnt;
    lane_mask_t                   exec_valid;
    exec_t     [`ISSUE_WIDTH-1:0] exec_entries;
    reg_addr_t [`ISSUE_WIDTH-1:0] raddr1;
    reg_addr_t [`ISSUE_WIDTH-1:0] raddr2;
    xlen_t     [`ISSUE_WIDTH-1:0] rdata1;
    xlen_t     [`ISSUE_WIDTH-1:0] rdata2;

    fetch_window i_fetch_window (
        .clk            (clk),
        .rst            (rst),
        .fetch_bundle_i (fetch_bundle_i),
        .issue_cnt_i    (issue_cnt),
        .window_o       (window),
        .window_valid_o (window_valid),
        .fetch_addr_o   (fetch_addr_o)
    );

    for (genvar g = 0; g < `ISSUE_WIDTH; g++) begin : g_lane
        insn_decode i_decode (
            .insn_i  (window[g]),
            .valid_i (window_valid[g]),
            .uop_o   (uops[g])
        );
        assign raddr1[g] = uops[g].rs1;
        assign raddr2[g] = uops[g].rs2;
    end

    issue_logic i_issue_logic (
        .uops_i       (uops),
        .exec_valid_i (exec_valid),
        .exec_i       (exec_entries),
        .issue_mask_o (issue_mask),
        .issue_cnt_o  (issue_cnt)
    );

    reg_file i_reg_file (
        .clk       (clk),
        .rst       (rst),
        .raddr1_i  (raddr1),
        .raddr2_i  (raddr2),
        .wen_i     (commit_valid_o),
        .wbundle_i (commit_o),
        .rdata1_o  (rdata1),
        .rdata2_o  (rdata2)
    );

    exec_pipe i_exec_pipe (
        .clk            (clk),
        .rst            (rst),
        .uops_i         (uops),
        .issue_mask_i   (issue_mask),
        .rdata1_i       (rdata1),
        .rdata2_i       (rdata2),
        .exec_valid_o   (exec_valid),
        .exec_o         (exec_entries),
        .commit_valid_o (commit_valid_o),
        .commit_o       (commit_o)
    );

endmodule

/* tb.f */
+incdir+source
source/core_pkg.sv
source/fetch_window.sv
source/insn_decode.sv
source/issue_logic.sv
source/reg_file.sv
source/alu.sv
source/exec_pipe.sv
source/superscalar_core.sv
tb/tb_superscalar_core.sv

/* tb/tb_superscalar_core.sv */
`timescale 1ns/10ps
`include "core_consts.svh"

module tb_superscalar_core;
    import core_pkg::*;

    localparam int PROG_LEN = 400;
    localparam int CLK_PERIOD = 8;
    localparam int RESET_CYCLES = 16;
    localparam int DRAIN_CYCLES = 8;
    localparam insn_t NOP = 32'h0000_0013;
    // operation kinds of the nine register-immediate forms
    localparam int IMM_KIND [9] = '{0, 3, 4, 5, 8, 9, 2, 6, 7};

    logic           clk;
    logic           rst;
    fetch_addr_t    fetch_addr;
    fetch_bundle_t  fetch_bundle;
    lane_mask_t     commit_valid;
    commit_bundle_t commit;

    insn_t     imem [PROG_LEN];
    xlen_t     model_regs [`NUM_REGS];
    reg_addr_t exp_rd [$];
    xlen_t     exp_data [$];
    int        seed;
    int        seen;

    superscalar_core i_dut (
        .clk            (clk),
        .rst            (rst),
        .fetch_addr_o   (fetch_addr),
        .fetch_bundle_i (fetch_bundle),
        .commit_valid_o (commit_valid),
        .commit_o       (commit)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    function automatic insn_t fetch_word(fetch_addr_t addr);
        if (addr < PROG_LEN) begin
            return imem[addr];
        end
        return NOP;
    endfunction

    // kinds: add sub sll slt sltu xor srl sra or and
    function automatic xlen_t model_alu(int kind, xlen_t a, xlen_t b);
        case (kind)
            0: return a + b;
            1: return a - b;
            2: return a << b[4:0];
            3: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            4: return (a < b) ? 32'd1 : 32'd0;
            5: return a ^ b;
            6: return a >> b[4:0];
            7: return $signed(a) >>> b[4:0];
            8: return a | b;
            default: return a & b;
        endcase
    endfunction

    function automatic logic [2:0] kind_funct3(int kind);
        case (kind)
            0, 1: return 3'd0;
            2: return 3'd1;
            3: return 3'd2;
            4: return 3'd3;
            5: return 3'd4;
            6, 7: return 3'd5;
            8: return 3'd6;
            default: return 3'd7;
        endcase
    endfunction

    // random program plus the sequential reference run over it
    task automatic build_program();
        int          form;
        int          kind;
        reg_addr_t   rd;
        reg_addr_t   rs1;
        reg_addr_t   rs2;
        logic [11:0] imm12;
        logic [2:0]  f3;
        logic [6:0]  f7;
        xlen_t       b;
        xlen_t       result;
        for (int r = 0; r < `NUM_REGS; r++) begin
            model_regs[r] = '0;
        end
        for (int n = 0; n < PROG_LEN; n++) begin
            form = $unsigned($random(seed)) % 19;
            // x0..x7 only, so dependencies are dense
            rd = reg_addr_t'($random(seed) & 7);
            rs1 = reg_addr_t'($random(seed) & 7);
            rs2 = reg_addr_t'($random(seed) & 7);
            imm12 = 12'($random(seed));
            kind = (form < 10) ? form : IMM_KIND[form - 10];
            f3 = kind_funct3(kind);
            f7 = (kind == 1 || kind == 7) ? 7'b0100000 : 7'b0000000;
            if (form < 10) begin
                imem[n] = {f7, rs2, rs1, f3, rd, `OPC_OP};
                b = model_regs[rs2];
            end else begin
                if (kind == 2 || kind == 6 || kind == 7) begin
                    imm12 = {f7, imm12[4:0]};
                end
                imem[n] = {imm12, rs1, f3, rd, `OPC_OP_IMM};
                b = {{20{imm12[11]}}, imm12};
            end
            result = model_alu(kind, model_regs[rs1], b);
            if (rd != '0) begin
                model_regs[rd] = result;
                exp_rd.push_back(rd);
                exp_data.push_back(result);
            end
        end
    endtask

    task automatic stop_on_error(string msg);
        $display("%s", msg);
        $display("Errors found");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic check_rd(reg_addr_t got, reg_addr_t exp);
        if (got !== exp) begin
            stop_on_error($sformatf("FAIL %0t commit %0d: rd x%0d, expected x%0d",
                                    $time, seen, got, exp));
        end
    endtask

    task automatic check_data(xlen_t got, xlen_t exp);
        if (got !== exp) begin
            stop_on_error($sformatf("FAIL %0t commit %0d: data 0x%08h, expected 0x%08h",
                                    $time, seen, got, exp));
        end
    endtask

    task automatic check_fetch_addr(fetch_addr_t got, fetch_addr_t lo, fetch_addr_t hi);
        if ($isunknown(got) || got < lo || got > hi) begin
            stop_on_error($sformatf("FAIL %0t fetch_addr_o %0d, expected %0d to %0d",
                                    $time, got, lo, hi));
        end
    endtask

    task automatic take_commit(int lane);
        if (exp_rd.size() == 0) begin
            stop_on_error($sformatf("unexpected commit on lane %0d at %0t after %0d commits",
                                    lane, $time, seen));
        end else begin
            check_rd(commit[lane].rd, exp_rd.pop_front());
            check_data(commit[lane].data, exp_data.pop_front());
            seen++;
        end
    endtask

    initial begin
        clk = 1'b0;
        rst = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        rst = 1'b0;
    end

    // instruction memory answers the current fetch address
    initial begin
        fetch_bundle = {`ISSUE_WIDTH{NOP}};
        forever begin
            @(posedge clk);
            #1;
            for (int k = 0; k < `ISSUE_WIDTH; k++) begin
                fetch_bundle[k] <= fetch_word(fetch_addr + fetch_addr_t'(k));
            end
        end
    end

    initial begin
        #((PROG_LEN + RESET_CYCLES + 40) * 4 * CLK_PERIOD);
        $display("watchdog expired with %0d commits seen and %0d still expected",
                 seen, exp_rd.size());
        $display("Errors found");
        $fatal(1, "watchdog timeout");
    end

    initial begin
        fetch_addr_t prev_addr;
        int          idle;
        seed = 32'h6b45_f6d3;
        seen = 0;
        build_program();
        repeat (RESET_CYCLES) begin
            @(negedge clk);
            if (commit_valid !== '0) begin
                stop_on_error("commit_valid_o is not zero while reset is held");
            end
            check_fetch_addr(fetch_addr, '0, '0);
        end
        prev_addr = '0;
        idle = 0;
        // a few extra cycles after the queue drains catch stray commits
        while (idle < DRAIN_CYCLES) begin
            @(negedge clk);
            check_fetch_addr(fetch_addr, prev_addr, prev_addr + 4);
            prev_addr = fetch_addr;
            for (int i = 0; i < `ISSUE_WIDTH; i++) begin
                if (commit_valid[i]) begin
                    take_commit(i);
                end
            end
            if (exp_rd.size() == 0) begin
                idle++;
            end
        end
        $display("No errors");
        $finish;
    end

endmodule
